// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = i2c_eeprom_tb
FILE_LIST = files.f
OBJ_DIR   = obj_dir
PASS_TEXT = Regression passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the regression"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// File: files.f
logic/i2c_eeprom_pkg.sv
logic/i2c_line_sync.sv
logic/i2c_deserializer.sv
logic/i2c_serializer.sv
logic/eeprom_addr_pointer.sv
logic/eeprom_array.sv
logic/i2c_eeprom_top.sv
tb/tb_clock_gen.sv
tb/i2c_eeprom_sva.sv
tb/i2c_eeprom_tb.sv

// File: logic/eeprom_addr_pointer.sv
`timescale 1ns/1ps

module eeprom_addr_pointer #(
    parameter int MEM_DEPTH = 2048
) (
    input  logic                      Clock,
    input  logic                      Reset,
    input  logic                      load,
    input  i2c_eeprom_pkg::mem_addr_t load_addr,
    input  logic                      inc,
    output i2c_eeprom_pkg::mem_addr_t pointer
);

    // depth is a power of two, so wrap is a mask
    localparam i2c_eeprom_pkg::mem_addr_t ADDR_MASK = i2c_eeprom_pkg::mem_addr_t'(MEM_DEPTH - 1);

    ////////////////////
    // pointer register
    ////////////////////

    always_ff @(posedge Clock or negedge Reset)
    begin
        if (!Reset)
        begin
            pointer <= '0;
        end
        else if (load)
        begin
            // load wins over a same-cycle increment
            pointer <= load_addr & ADDR_MASK;
        end
        else if (inc)
        begin
            pointer <= (pointer + 1'b1) & ADDR_MASK;
        end
    end

endmodule

// File: logic/eeprom_array.sv
`timescale 1ns/1ps

module eeprom_array #(
    parameter int MEM_DEPTH = 2048
) (
    input  logic                       Clock,
    input  i2c_eeprom_pkg::mem_write_t wr,
    input  i2c_eeprom_pkg::mem_addr_t  rd_addr,
    output i2c_eeprom_pkg::byte_t      read_data
);

    localparam int AW = $clog2(MEM_DEPTH);

    i2c_eeprom_pkg::byte_t mem [MEM_DEPTH];

    ////////////////////
    // storage
    ////////////////////

    always_ff @(posedge Clock)
    begin
        if (wr.en)
        begin
            mem[wr.addr[AW-1:0]] <= wr.data;
        end
    end

    // registered read, follows the pointer one cycle later
    always_ff @(posedge Clock)
    begin
        read_data <= mem[rd_addr[AW-1:0]];
    end

endmodule

// File: logic/i2c_deserializer.sv
`timescale 1ns/1ps

module i2c_deserializer (
    input  logic                        Clock,
    input  logic                        Reset,
    input  i2c_eeprom_pkg::bus_events_t events,
    input  logic [2:0]                  dev_addr_bits,
    input  i2c_eeprom_pkg::mem_addr_t   pointer,
    input  i2c_eeprom_pkg::ack_e        master_ack,
    input  logic                        master_ack_valid,
    output i2c_eeprom_pkg::mem_write_t  mem_wr,
    output logic                        pointer_load,
    output i2c_eeprom_pkg::mem_addr_t   load_addr,
    output logic                        pointer_inc,
    output logic                        ack_slot,
    output logic                        read_active,
    output logic                        selected
);

    i2c_eeprom_pkg::slave_state_e state;
    logic [3:0]                   bit_cnt;
    i2c_eeprom_pkg::byte_t        shift_in;
    i2c_eeprom_pkg::byte_t        addr_hi;
    logic                         wr_en;
    i2c_eeprom_pkg::mem_addr_t    wr_addr;
    i2c_eeprom_pkg::byte_t        wr_data;
    logic                         byte_done;
    logic                         ack_done;
    logic                         dev_match;

    // fall after the 8th rise opens the ack slot, fall after the 9th closes it
    assign byte_done = events.scl_fall && (bit_cnt == 4'd8);
    assign ack_done  = events.scl_fall && (bit_cnt == 4'd9);

    assign dev_match   = (shift_in[7:1] == {i2c_eeprom_pkg::DEV_TYPE, dev_addr_bits});
    assign read_active = (state == i2c_eeprom_pkg::READ_DATA);

    always_comb
    begin
        mem_wr.en   = wr_en;
        mem_wr.addr = wr_addr;
        mem_wr.data = wr_data;
    end

    ////////////////////
    // protocol FSM
    ////////////////////

    always_ff @(posedge Clock or negedge Reset)
    begin
        if (!Reset)
        begin
            state        <= i2c_eeprom_pkg::IDLE;
            bit_cnt      <= 4'd0;
            ack_slot     <= 1'b0;
            selected     <= 1'b0;
            wr_en        <= 1'b0;
            pointer_load <= 1'b0;
            pointer_inc  <= 1'b0;
        end
        else
        begin
            wr_en        <= 1'b0;
            pointer_load <= 1'b0;
            pointer_inc  <= 1'b0;

            if (events.stop)
            begin
                // a partial byte is simply dropped
                state    <= i2c_eeprom_pkg::IDLE;
                bit_cnt  <= 4'd0;
                ack_slot <= 1'b0;
                selected <= 1'b0;
            end
            else if (events.start)
            begin
                // plain or repeated start, control byte follows
                state    <= i2c_eeprom_pkg::CONTROL;
                bit_cnt  <= 4'd0;
                ack_slot <= 1'b0;
                selected <= 1'b0;
            end
            else
            begin
                if (events.scl_rise && (bit_cnt != 4'd9))
                begin
                    bit_cnt <= bit_cnt + 4'd1;
                end

                if (ack_done)
                begin
                    bit_cnt  <= 4'd0;
                    ack_slot <= 1'b0;
                end

                if (byte_done)
                begin
                    case (state)
                        i2c_eeprom_pkg::CONTROL:
                        begin
                            if (dev_match)
                            begin
                                ack_slot <= 1'b1;
                                selected <= 1'b1;
                                // r/w bit, 1 is read
                                state    <= shift_in[0] ? i2c_eeprom_pkg::READ_DATA
                                                        : i2c_eeprom_pkg::ADDR_HI;
                            end
                            else
                            begin
                                state <= i2c_eeprom_pkg::IGNORE;
                            end
                        end
                        i2c_eeprom_pkg::ADDR_HI:
                        begin
                            ack_slot <= 1'b1;
                            state    <= i2c_eeprom_pkg::ADDR_LO;
                        end
                        i2c_eeprom_pkg::ADDR_LO:
                        begin
                            ack_slot     <= 1'b1;
                            pointer_load <= 1'b1;
                            state        <= i2c_eeprom_pkg::WRITE_DATA;
                        end
                        i2c_eeprom_pkg::WRITE_DATA:
                        begin
                            ack_slot    <= 1'b1;
                            wr_en       <= 1'b1;
                            pointer_inc <= 1'b1;
                        end
                        default:
                        begin
                            state <= state;
                        end
                    endcase
                end

                // master nack ends a sequential read
                if (read_active && master_ack_valid && (master_ack == i2c_eeprom_pkg::NACK))
                begin
                    state    <= i2c_eeprom_pkg::IGNORE;
                    selected <= 1'b0;
                end
            end
        end
    end

    ////////////////////
    // byte assembly
    ////////////////////

    always_ff @(posedge Clock)
    begin
        if (events.scl_rise && (bit_cnt < 4'd8))
        begin
            shift_in <= {shift_in[6:0], events.sda};
        end

        if (byte_done)
        begin
            if (state == i2c_eeprom_pkg::ADDR_HI)
            begin
                addr_hi <= shift_in;
            end
            // low five bits of the second address byte are don't care
            if (state == i2c_eeprom_pkg::ADDR_LO)
            begin
                load_addr <= {addr_hi, shift_in[7:5]};
            end
            if (state == i2c_eeprom_pkg::WRITE_DATA)
            begin
                wr_addr <= pointer;
                wr_data <= shift_in;
            end
        end
    end

endmodule

// File: logic/i2c_eeprom_pkg.sv
package i2c_eeprom_pkg;

    ////////////////////
    // constants
    ////////////////////

    // 2K x 8 array, 11-bit word address
    localparam int MEM_ADDR_W = 11;

    // fixed device type, the low three address bits come from straps
    localparam logic [3:0] DEV_TYPE = 4'b1010;

    ////////////////////
    // types
    ////////////////////

    typedef logic [7:0] byte_t;
    typedef logic [MEM_ADDR_W-1:0] mem_addr_t;

    // value of the ninth bit on the bus
    typedef enum logic {
        ACK  = 1'b0,
        NACK = 1'b1
    } ack_e;

    typedef enum logic [2:0] {
        IDLE,
        CONTROL,
        ADDR_HI,
        ADDR_LO,
        WRITE_DATA,
        READ_DATA,
        IGNORE
    } slave_state_e;

    // synchronized line level plus one-cycle event pulses
    typedef struct packed {
        logic sda;
        logic scl_rise;
        logic scl_fall;
        logic start;
        logic stop;
    } bus_events_t;

    typedef struct packed {
        logic      en;
        mem_addr_t addr;
        byte_t     data;
    } mem_write_t;

endpackage

// File: logic/i2c_eeprom_top.sv
`timescale 1ns/1ps

module i2c_eeprom_top #(
    parameter int SYNC_STAGES = 2,
    parameter int MEM_DEPTH   = 2048
) (
    input  logic       Clock,
    input  logic       Reset,
    input  logic       scl,
    input  logic       sda,
    input  logic [2:0] dev_addr_bits,
    output logic       sda_pull_low,
    output logic       selected
);

    i2c_eeprom_pkg::bus_events_t events;
    i2c_eeprom_pkg::mem_write_t  mem_wr;
    i2c_eeprom_pkg::mem_addr_t   pointer;
    i2c_eeprom_pkg::mem_addr_t   load_addr;
    i2c_eeprom_pkg::byte_t       read_data;
    i2c_eeprom_pkg::ack_e        master_ack;
    logic                        master_ack_valid;
    logic                        pointer_load;
    logic                        pointer_inc;
    logic                        pointer_inc_rd;
    logic                        pointer_step;
    logic                        ack_slot;
    logic                        read_active;

    // write and read increments never coincide
    assign pointer_step = pointer_inc | pointer_inc_rd;

    i2c_line_sync #(
        .SYNC_STAGES(SYNC_STAGES)
    ) u_line_sync (
        .Clock  (Clock),
        .Reset  (Reset),
        .scl    (scl),
        .sda    (sda),
        .events (events)
    );

    i2c_deserializer u_deserializer (
        .Clock            (Clock),
        .Reset            (Reset),
        .events           (events),
        .dev_addr_bits    (dev_addr_bits),
        .pointer          (pointer),
        .master_ack       (master_ack),
        .master_ack_valid (master_ack_valid),
        .mem_wr           (mem_wr),
        .pointer_load     (pointer_load),
        .load_addr        (load_addr),
        .pointer_inc      (pointer_inc),
        .ack_slot         (ack_slot),
        .read_active      (read_active),
        .selected         (selected)
    );

    i2c_serializer u_serializer (
        .Clock            (Clock),
        .Reset            (Reset),
        .events           (events),
        .ack_slot         (ack_slot),
        .read_active      (read_active),
        .read_data        (read_data),
        .sda_pull_low     (sda_pull_low),
        .master_ack       (master_ack),
        .master_ack_valid (master_ack_valid),
        .pointer_inc_rd   (pointer_inc_rd)
    );

    eeprom_addr_pointer #(
        .MEM_DEPTH(MEM_DEPTH)
    ) u_addr_pointer (
        .Clock     (Clock),
        .Reset     (Reset),
        .load      (pointer_load),
        .load_addr (load_addr),
        .inc       (pointer_step),
        .pointer   (pointer)
    );

    eeprom_array #(
        .MEM_DEPTH(MEM_DEPTH)
    ) u_array (
        .Clock     (Clock),
        .wr        (mem_wr),
        .rd_addr   (pointer),
        .read_data (read_data)
    );

endmodule

// File: logic/i2c_line_sync.sv
`timescale 1ns/1ps

module i2c_line_sync #(
    parameter int SYNC_STAGES = 2
) (
    input  logic                        Clock,
    input  logic                        Reset,
    input  logic                        scl,
    input  logic                        sda,
    output i2c_eeprom_pkg::bus_events_t events
);

    logic [SYNC_STAGES-1:0] scl_pipe;
    logic [SYNC_STAGES-1:0] sda_pipe;
    logic                   scl_now;
    logic                   sda_now;
    logic                   scl_prev;
    logic                   sda_prev;

    assign scl_now = scl_pipe[SYNC_STAGES-1];
    assign sda_now = sda_pipe[SYNC_STAGES-1];

    ////////////////////
    // synchronizer chains
    ////////////////////

    // idle bus is high on both lines
    always_ff @(posedge Clock or negedge Reset)
    begin
        if (!Reset)
        begin
            scl_pipe <= '1;
            sda_pipe <= '1;
            scl_prev <= 1'b1;
            sda_prev <= 1'b1;
        end
        else
        begin
            scl_pipe[0] <= scl;
            sda_pipe[0] <= sda;
            for (int i = 1; i < SYNC_STAGES; i++)
            begin
                scl_pipe[i] <= scl_pipe[i-1];
                sda_pipe[i] <= sda_pipe[i-1];
            end
            scl_prev <= scl_now;
            sda_prev <= sda_now;
        end
    end

    ////////////////////
    // event pulses
    ////////////////////

    // start and stop only count when scl was high on both samples
    always_ff @(posedge Clock or negedge Reset)
    begin
        if (!Reset)
        begin
            events <= '{sda: 1'b1, default: 1'b0};
        end
        else
        begin
            events.sda      <= sda_now;
            events.scl_rise <= scl_now & ~scl_prev;
            events.scl_fall <= ~scl_now & scl_prev;
            events.start    <= scl_now & scl_prev & sda_prev & ~sda_now;
            events.stop     <= scl_now & scl_prev & ~sda_prev & sda_now;
        end
    end

endmodule

// File: logic/i2c_serializer.sv
`timescale 1ns/1ps

module i2c_serializer (
    input  logic                        Clock,
    input  logic                        Reset,
    input  i2c_eeprom_pkg::bus_events_t events,
    input  logic                        ack_slot,
    input  logic                        read_active,
    input  i2c_eeprom_pkg::byte_t       read_data,
    output logic                        sda_pull_low,
    output i2c_eeprom_pkg::ack_e        master_ack,
    output logic                        master_ack_valid,
    output logic                        pointer_inc_rd
);

    i2c_eeprom_pkg::byte_t tx_byte;
    logic [3:0]            tx_cnt;
    logic                  tx_busy;
    logic                  mack_wait;
    logic                  load_now;

    // next read byte goes out at the fall ending our ack or the master's ack
    assign load_now = events.scl_fall && read_active && (ack_slot || mack_wait);

    ////////////////////
    // sda driver
    ////////////////////

    always_ff @(posedge Clock or negedge Reset)
    begin
        if (!Reset)
        begin
            sda_pull_low     <= 1'b0;
            tx_cnt           <= 4'd0;
            tx_busy          <= 1'b0;
            mack_wait        <= 1'b0;
            master_ack       <= i2c_eeprom_pkg::NACK;
            master_ack_valid <= 1'b0;
            pointer_inc_rd   <= 1'b0;
        end
        else
        begin
            master_ack_valid <= 1'b0;
            pointer_inc_rd   <= 1'b0;

            if (events.start || events.stop)
            begin
                sda_pull_low <= 1'b0;
                tx_busy      <= 1'b0;
                mack_wait    <= 1'b0;
            end
            else if (load_now)
            begin
                // msb first, open drain so a 0 bit pulls low
                sda_pull_low   <= ~read_data[7];
                tx_cnt         <= 4'd1;
                tx_busy        <= 1'b1;
                mack_wait      <= 1'b0;
                pointer_inc_rd <= 1'b1;
            end
            else if (events.scl_fall)
            begin
                if (tx_busy && (tx_cnt == 4'd8))
                begin
                    // hand the line to the master for its ack bit
                    sda_pull_low <= 1'b0;
                    tx_busy      <= 1'b0;
                    mack_wait    <= 1'b1;
                end
                else if (tx_busy)
                begin
                    sda_pull_low <= ~tx_byte[7];
                    tx_cnt       <= tx_cnt + 4'd1;
                end
                else
                begin
                    sda_pull_low <= 1'b0;
                    mack_wait    <= 1'b0;
                end
            end
            else if (ack_slot)
            begin
                sda_pull_low <= 1'b1;
            end

            if (mack_wait && events.scl_rise)
            begin
                master_ack       <= i2c_eeprom_pkg::ack_e'(events.sda);
                master_ack_valid <= 1'b1;
            end
        end
    end

    // shift register for read bytes
    always_ff @(posedge Clock)
    begin
        if (load_now)
        begin
            tx_byte <= {read_data[6:0], 1'b0};
        end
        else if (events.scl_fall && tx_busy)
        begin
            tx_byte <= {tx_byte[6:0], 1'b0};
        end
    end

endmodule

// File: tb/i2c_eeprom_sva.sv
`timescale 1ns/1ps

module i2c_eeprom_sva (
    input logic                        Clock,
    input logic                        Reset,
    input logic                        sda_pull_low,
    input logic                        selected,
    input i2c_eeprom_pkg::mem_write_t  mem_wr,
    input i2c_eeprom_pkg::bus_events_t events
);

    // slave drives the line only while addressed
    pull_low_only_when_selected: assert property (
        @(posedge Clock) disable iff (!Reset) sda_pull_low |-> selected
    ) else $error("sda_pull_low high while selected is low");

    write_only_in_transfer: assert property (
        @(posedge Clock) disable iff (!Reset) mem_wr.en |-> selected
    ) else $error("memory write enable high outside a transfer");

    // start and stop are exclusive
    start_stop_exclusive: assert property (
        @(posedge Clock) disable iff (!Reset) !(events.start && events.stop)
    ) else $error("start and stop in the same cycle");

endmodule

bind i2c_eeprom_top i2c_eeprom_sva sva0 (
    .Clock        (Clock),
    .Reset        (Reset),
    .sda_pull_low (sda_pull_low),
    .selected     (selected),
    .mem_wr       (mem_wr),
    .events       (events)
);

// File: tb/i2c_eeprom_tb.sv
`timescale 1ns/1ps

module i2c_eeprom_tb;

    localparam logic [2:0] STRAP             = 3'b101;
    localparam int         MAX_PATTERNS      = 20;
    localparam int         WORDS_PER_LINE    = 12;
    localparam int         BITS_PER_TRANSFER = 120;
    localparam int         CYCLE_MARGIN      = 2000;

    logic       Clock;
    logic       Reset;
    logic       scl_drv;
    logic       sda_drv;
    logic       bus_sda;
    logic [2:0] dev_addr_bits;
    logic       sda_pull_low;
    logic       selected;

    // op, dev, addr, count, then eight data bytes per line
    logic [15:0]           patterns [MAX_PATTERNS * WORDS_PER_LINE];
    i2c_eeprom_pkg::byte_t page_bytes [8];
    int                    n_patterns;
    int                    errors;
    int                    checks;
    int                    cycles = 0;
    int                    cycle_limit;
    int                    seed;

    // open drain bus, the slave can only pull low
    assign bus_sda = sda_drv & ~sda_pull_low;

    tb_clock_gen clock_gen0 (
        .Clock (Clock)
    );

    i2c_eeprom_top #(
        .SYNC_STAGES (2),
        .MEM_DEPTH   (2048)
    ) dut0 (
        .Clock         (Clock),
        .Reset         (Reset),
        .scl           (scl_drv),
        .sda           (bus_sda),
        .dev_addr_bits (dev_addr_bits),
        .sda_pull_low  (sda_pull_low),
        .selected      (selected)
    );

    ////////////////////
    // compare tasks
    ////////////////////

    task automatic check_ack(input string name, input i2c_eeprom_pkg::ack_e got,
                             input i2c_eeprom_pkg::ack_e want);
        checks++;
        if (got !== want)
        begin
            errors++;
            $display("ERROR %s: expected %h, got %h", name, want, got);
        end
    endtask

    task automatic check_byte(input string name, input i2c_eeprom_pkg::byte_t got,
                              input i2c_eeprom_pkg::byte_t want);
        checks++;
        if (got !== want)
        begin
            errors++;
            $display("ERROR %s: expected %h, got %h", name, want, got);
        end
    endtask

    task automatic expect_selected(input logic want);
        checks++;
        if (selected !== want)
        begin
            errors++;
            $display("ERROR selected: expected %h, got %h", want, selected);
        end
    endtask

    ////////////////////
    // bus master
    ////////////////////

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge Clock);
    endtask

    // sda moves only while scl is low, sampled mid high phase
    task automatic clock_bit(input logic value, output logic sampled);
        wait_cycles(2);
        sda_drv = value;
        wait_cycles(6);
        scl_drv = 1'b1;
        wait_cycles(4);
        sampled = bus_sda;
        wait_cycles(4);
        scl_drv = 1'b0;
    endtask

    // also serves as repeated start when scl is low
    task automatic bus_start();
        wait_cycles(6);
        sda_drv = 1'b1;
        wait_cycles(2);
        scl_drv = 1'b1;
        wait_cycles(8);
        sda_drv = 1'b0;
        wait_cycles(8);
        scl_drv = 1'b0;
    endtask

    task automatic bus_stop();
        wait_cycles(2);
        sda_drv = 1'b0;
        wait_cycles(6);
        scl_drv = 1'b1;
        wait_cycles(8);
        sda_drv = 1'b1;
        wait_cycles(8);
    endtask

    task automatic send_byte(input i2c_eeprom_pkg::byte_t value,
                             output i2c_eeprom_pkg::ack_e ack);
        logic sampled;
        for (int i = 7; i >= 0; i--)
        begin
            clock_bit(value[i], sampled);
        end
        clock_bit(1'b1, sampled);
        ack = i2c_eeprom_pkg::ack_e'(sampled);
    endtask

    task automatic read_byte(input i2c_eeprom_pkg::ack_e give,
                             output i2c_eeprom_pkg::byte_t value);
        logic sampled;
        for (int i = 7; i >= 0; i--)
        begin
            clock_bit(1'b1, sampled);
            value[i] = sampled;
        end
        clock_bit(give, sampled);
    endtask

    function automatic i2c_eeprom_pkg::byte_t control_byte(input logic [2:0] dev, input logic rw);
        return {i2c_eeprom_pkg::DEV_TYPE, dev, rw};
    endfunction

    function automatic i2c_eeprom_pkg::byte_t pattern_byte(input int base, input int index);
        return i2c_eeprom_pkg::byte_t'(patterns[base + 4 + index]);
    endfunction

    ////////////////////
    // transfers
    ////////////////////

    // start, write control byte and both address bytes
    task automatic send_address(input logic [2:0] dev, input i2c_eeprom_pkg::mem_addr_t addr,
                                output logic acked);
        i2c_eeprom_pkg::ack_e ack;
        i2c_eeprom_pkg::ack_e want;
        want = (dev == STRAP) ? i2c_eeprom_pkg::ACK : i2c_eeprom_pkg::NACK;
        bus_start();
        send_byte(control_byte(dev, 1'b0), ack);
        check_ack("control ack", ack, want);
        expect_selected(dev == STRAP);
        acked = (ack == i2c_eeprom_pkg::ACK);
        if (acked)
        begin
            // bits 10..3, then bits 2..0 at the top of the second byte
            send_byte(addr[10:3], ack);
            check_ack("address high ack", ack, i2c_eeprom_pkg::ACK);
            send_byte({addr[2:0], 5'b00000}, ack);
            check_ack("address low ack", ack, i2c_eeprom_pkg::ACK);
        end
    endtask

    // master acks every byte but the last
    task automatic read_phase(input logic [2:0] dev, input int base, input int count,
                              input logic from_page);
        i2c_eeprom_pkg::ack_e  ack;
        i2c_eeprom_pkg::ack_e  give;
        i2c_eeprom_pkg::byte_t got;
        i2c_eeprom_pkg::byte_t want;
        bus_start();
        send_byte(control_byte(dev, 1'b1), ack);
        check_ack("read control ack", ack, i2c_eeprom_pkg::ACK);
        expect_selected(1'b1);
        for (int i = 0; i < count; i++)
        begin
            give = (i == count - 1) ? i2c_eeprom_pkg::NACK : i2c_eeprom_pkg::ACK;
            read_byte(give, got);
            want = from_page ? page_bytes[i] : pattern_byte(base, i);
            check_byte($sformatf("read data %0d", i), got, want);
        end
    endtask

    task automatic run_pattern(input int line);
        int                        base;
        logic [7:0]                op;
        logic [2:0]                dev;
        i2c_eeprom_pkg::mem_addr_t addr;
        int                        count;
        int                        errors_before;
        logic                      acked;
        logic                      sampled;
        i2c_eeprom_pkg::ack_e      ack;
        i2c_eeprom_pkg::byte_t     data;
        base          = line * WORDS_PER_LINE;
        op            = patterns[base][7:0];
        dev           = patterns[base + 1][2:0];
        addr          = i2c_eeprom_pkg::mem_addr_t'(patterns[base + 2]);
        count         = int'(patterns[base + 3]);
        errors_before = errors;
        case (op)
            8'h01, 8'h05:
            begin
                // page line data comes from the seeded generator
                for (int i = 0; op == 8'h05 && i < count; i++)
                begin
                    page_bytes[i] = i2c_eeprom_pkg::byte_t'($random(seed));
                end
                send_address(dev, addr, acked);
                for (int i = 0; acked && i < count; i++)
                begin
                    data = (op == 8'h05) ? page_bytes[i] : pattern_byte(base, i);
                    send_byte(data, ack);
                    check_ack($sformatf("data ack %0d", i), ack, i2c_eeprom_pkg::ACK);
                end
                bus_stop();
            end
            8'h02, 8'h06:
            begin
                send_address(dev, addr, acked);
                if (acked)
                begin
                    read_phase(dev, base, count, op == 8'h06);
                end
                bus_stop();
            end
            8'h03:
            begin
                read_phase(dev, base, count, 1'b0);
                bus_stop();
            end
            8'h04:
            begin
                send_address(dev, addr, acked);
                // upper half of the byte, then stop
                data = pattern_byte(base, 0);
                for (int i = 7; i >= 4; i--)
                begin
                    clock_bit(data[i], sampled);
                end
                bus_stop();
            end
            default:
            begin
                errors++;
                $display("pattern line %0d holds an unknown operation %0h", line + 1, op);
            end
        endcase
        $display("test %0d: op %0h dev %0d addr %h count %0d, %0d new errors",
                 line + 1, op, dev, addr, count, errors - errors_before);
    endtask

    ////////////////////
    // run control
    ////////////////////

    always @(posedge Clock)
    begin
        cycles <= cycles + 1;
        if (cycles > cycle_limit)
        begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Regression failed");
            $finish;
        end
    end

    initial
    begin
        Reset         = 1'b0;
        scl_drv       = 1'b1;
        sda_drv       = 1'b1;
        dev_addr_bits = STRAP;
        errors        = 0;
        checks        = 0;
        seed          = 32'h344b;
        n_patterns    = 0;
        $readmemh("tb/i2c_patterns.txt", patterns);
        while (n_patterns < MAX_PATTERNS && patterns[n_patterns * WORDS_PER_LINE] !== 16'h0000)
        begin
            n_patterns++;
        end
        cycle_limit = n_patterns * BITS_PER_TRANSFER * 16 + CYCLE_MARGIN;
        repeat (4) @(posedge Clock);
        @(negedge Clock);
        Reset = 1'b1;
        wait_cycles(4);
        for (int n = 0; n < n_patterns; n++)
        begin
            run_pattern(n);
        end
        $display("%0d tests, %0d checks, %0d errors", n_patterns, checks, errors);
        if (errors == 0)
        begin
            $display("Regression passed");
        end
        else
        begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: tb/i2c_patterns.txt
// op dev addr count d0 d1 d2 d3 d4 d5 d6 d7 (hex, data is write data or expected read data)
// op 01 write, 02 random read, 03 current read, 04 stop inside a byte, 05 random page, 06 page read
01 5 0123 1 a5 00 00 00 00 00 00 00
02 5 0123 1 a5 00 00 00 00 00 00 00
01 2 0123 1 3c 00 00 00 00 00 00 00
02 5 0123 1 a5 00 00 00 00 00 00 00
05 5 0200 8 00 00 00 00 00 00 00 00
06 5 0200 8 00 00 00 00 00 00 00 00
01 5 0300 2 11 22 00 00 00 00 00 00
02 5 0300 1 11 00 00 00 00 00 00 00
03 5 0000 1 22 00 00 00 00 00 00 00
01 5 0040 1 77 00 00 00 00 00 00 00
04 5 0040 1 e8 00 00 00 00 00 00 00
02 5 0040 1 77 00 00 00 00 00 00 00
01 5 07ff 2 9a 6b 00 00 00 00 00 00
02 5 07ff 2 9a 6b 00 00 00 00 00 00
02 5 0000 1 6b 00 00 00 00 00 00 00
// end marker
00 0 0000 0 00 00 00 00 00 00 00 00

// File: tb/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic Clock
);

    // 100 ns period
    localparam int HALF_PERIOD = 50;

    initial
    begin
        Clock = 1'b0;
        forever #(HALF_PERIOD) Clock = ~Clock;
    end

endmodule
